//--- logic/cfu_params.svh
`ifndef CFU_PARAMS_SVH
`define CFU_PARAMS_SVH

// Command interface widths
`define CFU_XLEN           32
`define CFU_FUNCT_ID_BITS  10
`define CFU_FUNCT7_BITS    7

// Buffer depth is 2**CFU_ADDR_BITS, also the width of K
`define CFU_ADDR_BITS      10

// Datapath
`define CFU_OP_BITS        8
`define CFU_ACC_BITS       32
`define CFU_LANES          4

`endif

//--- logic/cfu_cmd_pkg.sv
`include "cfu_params.svh"

package cfu_cmd_pkg;

  // Opcodes carried in the funct7 field
  typedef enum logic [`CFU_FUNCT7_BITS-1:0] {
    WRITE_A = 7'd1,
    WRITE_B = 7'd2,
    COMPUTE = 7'd3,
    READ    = 7'd4
  } cfu_opcode_e;

  typedef struct packed {
    logic [`CFU_FUNCT_ID_BITS-1:0] function_id;
    logic [`CFU_XLEN-1:0]          inputs_0;
    logic [`CFU_XLEN-1:0]          inputs_1;
  } cfu_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    START,
    WAIT,
    RESPOND
  } decode_state_e;

endpackage

//--- logic/cfu_data_pkg.sv
`include "cfu_params.svh"

package cfu_data_pkg;

  typedef logic signed [`CFU_OP_BITS-1:0]            operand_t;
  // Four signed bytes, lane 0 in the top byte
  typedef logic [`CFU_LANES*`CFU_OP_BITS-1:0]        b_word_t;
  typedef logic signed [`CFU_ACC_BITS-1:0]           acc_t;
  typedef logic [`CFU_ADDR_BITS-1:0]                 buf_addr_t;
  typedef logic [$clog2(`CFU_LANES)-1:0]             lane_idx_t;

  typedef struct packed {
    acc_t lane0;
    acc_t lane1;
    acc_t lane2;
    acc_t lane3;
  } result_row_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } engine_state_e;

endpackage

//--- logic/cmd_decode.sv
`timescale 1ns/1ps
`include "cfu_params.svh"

module cmd_decode (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid,
  input  cfu_cmd_pkg::cfu_cmd_t   cmd,
  input  logic                    rsp_ready,
  output logic                    cmd_ready,
  output logic                    rsp_valid,
  output logic                    a_wr,
  output logic                    b_wr,
  output cfu_data_pkg::buf_addr_t wr_addr,
  output cfu_data_pkg::operand_t  a_wr_data,
  output cfu_data_pkg::b_word_t   b_wr_data,
  output logic                    start,
  output cfu_data_pkg::buf_addr_t k_len,
  input  logic                    done,
  output logic                    capture,
  output cfu_data_pkg::lane_idx_t lane
);

  import cfu_cmd_pkg::*;

  decode_state_e state;
  decode_state_e state_next;
  cfu_opcode_e   opcode;
  logic          accept;

  // funct7 sits above funct3 in the function id
  assign opcode = cfu_opcode_e'(cmd.function_id[`CFU_FUNCT_ID_BITS-1 -: `CFU_FUNCT7_BITS]);
  assign accept = (state == IDLE) && cmd_valid;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (cmd_valid) begin
          state_next = (opcode == COMPUTE) ? START : RESPOND;
        end
      end
      START: state_next = WAIT;
      WAIT: begin
        if (done) begin
          state_next = RESPOND;
        end
      end
      RESPOND: begin
        // Hold the response until the host takes it
        if (rsp_ready) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Buffer writes, address in inputs_0 and data in inputs_1
  assign a_wr      = accept && (opcode == WRITE_A);
  assign b_wr      = accept && (opcode == WRITE_B);
  assign wr_addr   = cmd.inputs_0[`CFU_ADDR_BITS-1:0];
  assign a_wr_data = cmd.inputs_1[`CFU_OP_BITS-1:0];
  assign b_wr_data = cmd.inputs_1;

  // Command is still held by the host during START
  assign start = (state == START);
  assign k_len = cmd.inputs_0[`CFU_ADDR_BITS-1:0];

  assign capture = accept && (opcode == READ);
  assign lane    = cmd.inputs_1[$clog2(`CFU_LANES)-1:0];

  assign rsp_valid = (state == RESPOND);
  assign cmd_ready = rsp_valid;

endmodule

//--- logic/operand_buffer.sv
`timescale 1ns/1ps
`include "cfu_params.svh"

module operand_buffer #(
  parameter int DATA_BITS = 8
) (
  input  logic                    clk,
  input  logic                    wr,
  input  cfu_data_pkg::buf_addr_t addr,
  input  logic [DATA_BITS-1:0]    wr_data,
  output logic [DATA_BITS-1:0]    rd_data
);

  localparam int DEPTH = 1 << `CFU_ADDR_BITS;

  logic [DATA_BITS-1:0] mem [DEPTH];

  // Single port, read data one cycle after the address
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[addr] <= wr_data;
    end
    rd_data <= mem[addr];
  end

endmodule

//--- logic/mac_pe.sv
`timescale 1ns/1ps

module mac_pe (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clear,
  input  cfu_data_pkg::operand_t west,
  input  cfu_data_pkg::operand_t north,
  output cfu_data_pkg::operand_t east,
  output cfu_data_pkg::acc_t     acc
);

  import cfu_data_pkg::*;

  acc_t prod;

  // Signed 8x8 product, sign-extended to accumulator width
  assign prod = west * north;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      east <= '0;
      acc  <= '0;
    end else begin
      east <= west;
      if (clear) begin
        acc <= '0;
      end else begin
        acc <= acc + prod;  // wraps at 32 bits
      end
    end
  end

endmodule

//--- logic/systolic_row.sv
`timescale 1ns/1ps
`include "cfu_params.svh"

module systolic_row (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      clear,
  input  cfu_data_pkg::operand_t    a_in,
  input  cfu_data_pkg::b_word_t     b_in,
  output cfu_data_pkg::result_row_t row
);

  import cfu_data_pkg::*;

  // A moves west to east, one register per cell
  operand_t a_chain  [`CFU_LANES+1];
  operand_t north    [`CFU_LANES];
  acc_t     lane_acc [`CFU_LANES];

  assign a_chain[0] = a_in;

  for (genvar j = 0; j < `CFU_LANES; j++) begin : g_lane
    operand_t b_byte;

    assign b_byte = b_in[(`CFU_LANES-1-j)*`CFU_OP_BITS +: `CFU_OP_BITS];

    if (j == 0) begin : g_no_skew
      assign north[j] = b_byte;
    end else begin : g_skew
      // Lane j waits j cycles to meet its copy of A
      operand_t skew_q [j];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int i = 0; i < j; i++) begin
            skew_q[i] <= '0;
          end
        end else begin
          skew_q[0] <= b_byte;
          for (int i = 1; i < j; i++) begin
            skew_q[i] <= skew_q[i-1];
          end
        end
      end

      assign north[j] = skew_q[j-1];
    end

    mac_pe u_pe (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (clear),
      .west  (a_chain[j]),
      .north (north[j]),
      .east  (a_chain[j+1]),
      .acc   (lane_acc[j])
    );
  end

  assign row = {lane_acc[0], lane_acc[1], lane_acc[2], lane_acc[3]};

endmodule

//--- logic/matmul_engine.sv
`timescale 1ns/1ps

module matmul_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  cfu_data_pkg::buf_addr_t   k_len,
  input  cfu_data_pkg::operand_t    a_rd,
  input  cfu_data_pkg::b_word_t     b_rd,
  output logic                      busy,
  output cfu_data_pkg::buf_addr_t   rd_addr,
  output logic                      done,
  output cfu_data_pkg::result_row_t row
);

  import cfu_data_pkg::*;

  // Buffer latency 1, B skew 3, A pass-through 3
  localparam int DRAIN_CYCLES = 7;

  engine_state_e state;
  buf_addr_t     addr_cnt;
  buf_addr_t     k_q;
  logic [2:0]    drain_cnt;
  logic          rd_valid;
  logic          clear;
  operand_t      a_feed;
  b_word_t       b_feed;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      addr_cnt  <= '0;
      k_q       <= '0;
      drain_cnt <= '0;
      rd_valid  <= 1'b0;
    end else begin
      // Read data lags the address by one cycle
      rd_valid <= (state == ISSUE);
      case (state)
        IDLE: begin
          if (start) begin
            k_q       <= k_len;
            addr_cnt  <= '0;
            drain_cnt <= '0;
            state     <= (k_len == '0) ? DRAIN : ISSUE;
          end
        end
        ISSUE: begin
          if (addr_cnt == k_q - 1'b1) begin
            state <= DRAIN;
          end else begin
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
        DRAIN: begin
          if (drain_cnt == 3'(DRAIN_CYCLES - 1)) begin
            state <= IDLE;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy    = (state != IDLE);
  assign rd_addr = addr_cnt;
  assign done    = (state == DRAIN) && (drain_cnt == 3'(DRAIN_CYCLES - 1));

  // Fresh sums for every run
  assign clear = start;

  // Zeros outside the K window keep the sums untouched
  assign a_feed = rd_valid ? a_rd : '0;
  assign b_feed = rd_valid ? b_rd : '0;

  systolic_row u_row (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (clear),
    .a_in  (a_feed),
    .b_in  (b_feed),
    .row   (row)
  );

endmodule

//--- logic/result_store.sv
`timescale 1ns/1ps
`include "cfu_params.svh"

module result_store (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      done,
  input  cfu_data_pkg::result_row_t row,
  input  logic                      capture,
  input  cfu_data_pkg::lane_idx_t   lane,
  output logic [`CFU_XLEN-1:0]      rsp_data
);

  import cfu_data_pkg::*;

  result_row_t row_q;
  acc_t        lane_sel;

  always_comb begin
    case (lane)
      2'd0:    lane_sel = row_q.lane0;
      2'd1:    lane_sel = row_q.lane1;
      2'd2:    lane_sel = row_q.lane2;
      default: lane_sel = row_q.lane3;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_q    <= '0;
      rsp_data <= '0;
    end else begin
      // Last row stays until the next compute finishes
      if (done) begin
        row_q <= row;
      end
      if (capture) begin
        rsp_data <= lane_sel;
      end
    end
  end

endmodule

//--- logic/cfu_top.sv
`timescale 1ns/1ps
`include "cfu_params.svh"

module cfu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  cfu_cmd_pkg::cfu_cmd_t cmd,
  output logic                  cmd_ready,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output logic [`CFU_XLEN-1:0]  rsp_data
);

  import cfu_data_pkg::*;

  logic        a_wr;
  logic        b_wr;
  buf_addr_t   wr_addr;
  operand_t    a_wr_data;
  b_word_t     b_wr_data;
  logic        start;
  buf_addr_t   k_len;
  logic        done;
  logic        capture;
  lane_idx_t   lane;
  logic        busy;
  buf_addr_t   eng_addr;
  buf_addr_t   buf_addr;
  operand_t    a_rd;
  b_word_t     b_rd;
  result_row_t row;

  cmd_decode u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rsp_ready (rsp_ready),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .a_wr      (a_wr),
    .b_wr      (b_wr),
    .wr_addr   (wr_addr),
    .a_wr_data (a_wr_data),
    .b_wr_data (b_wr_data),
    .start     (start),
    .k_len     (k_len),
    .done      (done),
    .capture   (capture),
    .lane      (lane)
  );

  // Engine owns the buffer ports while it runs
  assign buf_addr = busy ? eng_addr : wr_addr;

  operand_buffer #(.DATA_BITS($bits(operand_t))) u_buf_a (
    .clk     (clk),
    .wr      (a_wr),
    .addr    (buf_addr),
    .wr_data (a_wr_data),
    .rd_data (a_rd)
  );

  operand_buffer #(.DATA_BITS($bits(b_word_t))) u_buf_b (
    .clk     (clk),
    .wr      (b_wr),
    .addr    (buf_addr),
    .wr_data (b_wr_data),
    .rd_data (b_rd)
  );

  matmul_engine u_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .k_len   (k_len),
    .a_rd    (a_rd),
    .b_rd    (b_rd),
    .busy    (busy),
    .rd_addr (eng_addr),
    .done    (done),
    .row     (row)
  );

  result_store u_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .done     (done),
    .row      (row),
    .capture  (capture),
    .lane     (lane),
    .rsp_data (rsp_data)
  );

endmodule

//--- sim/cfu_tb.sv
`timescale 1ns/1ps
`include "cfu_params.svh"

module cfu_tb;

  import cfu_cmd_pkg::*;
  import cfu_data_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int K_SHORT    = 16;
  localparam int K_LONG     = 200;
  localparam int K_SMALL    = 7;
  // Commands issued by the sequence in the main block
  localparam int TOTAL_CMDS = (2*K_SHORT + 5) + (2*K_LONG + 5) + 5 + 5 + 5 + 2;
  localparam int WATCHDOG_CYCLES = TOTAL_CMDS * (1024 + 20);

  logic                 clk;
  logic                 rst_n;
  logic                 cmd_valid;
  cfu_cmd_t             cmd;
  logic                 cmd_ready;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [`CFU_XLEN-1:0] rsp_data;

  // Reference model state
  operand_t             model_a [1 << `CFU_ADDR_BITS];
  b_word_t              model_b [1 << `CFU_ADDR_BITS];
  acc_t                 model_row [`CFU_LANES];
  logic [31:0]          lcg_state;
  logic                 seen_cmd;
  logic                 short_cmd;
  logic                 check_rsp;
  logic [`CFU_XLEN-1:0] exp_rsp;
  int                   data_errors;
  int                   proto_errors;
  int                   cmd_count;

  cfu_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Quiet outputs through reset and until the first command
  quiet_start: assert property (@(posedge clk) !seen_cmd |-> !rsp_valid && !cmd_ready)
    else begin
      proto_errors++;
      $display("Response raised at %0t before any command was sent", $time);
    end

  ready_mirror: assert property (@(posedge clk) cmd_ready == rsp_valid)
    else begin
      proto_errors++;
      $display("cmd_ready differs from rsp_valid at %0t", $time);
    end

  short_latency: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && short_cmd && !rsp_valid |=> rsp_valid)
    else begin
      proto_errors++;
      $display("Write, read or unknown command not answered in one cycle at %0t", $time);
    end

  hold_response: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
      proto_errors++;
      $display("Response dropped or changed under back-pressure at %0t", $time);
    end

  response_done: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && rsp_ready |=> !rsp_valid)
    else begin
      proto_errors++;
      $display("Response still pending after the host took it at %0t", $time);
    end

  read_data: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && rsp_ready && check_rsp |-> rsp_data == exp_rsp)
    else begin
      data_errors++;
      $display("ERROR @ %0t: READ returned %h, expected %h",
               $time, $sampled(rsp_data), $sampled(exp_rsp));
    end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Wrapped signed sums, lane 0 taken from B bits 31:24
  function automatic void model_compute(input int k);
    operand_t b_byte;
    int       sum;
    for (int j = 0; j < `CFU_LANES; j++) begin
      sum = 0;
      for (int i = 0; i < k; i++) begin
        b_byte = model_b[i][31 - 8*j -: 8];
        sum = sum + int'(model_a[i]) * int'(b_byte);
      end
      model_row[j] = sum;
    end
  endfunction

  // Called on a falling edge, returns on the falling edge after the handshake
  task automatic run_cmd(input logic [`CFU_FUNCT7_BITS-1:0] funct7,
                         input logic [31:0] in0, input logic [31:0] in1,
                         input int hold, output int waited);
    cmd.function_id = {funct7, 3'b000};
    cmd.inputs_0    = in0;
    cmd.inputs_1    = in1;
    short_cmd       = (funct7 != COMPUTE);
    rsp_ready       = (hold == 0);
    cmd_valid       = 1'b1;
    seen_cmd        = 1'b1;
    cmd_count++;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!rsp_valid);
    cmd_valid = 1'b0;
    repeat (hold) @(negedge clk);
    rsp_ready = 1'b1;
    @(negedge clk);
  endtask

  task automatic write_operands(input int k);
    logic [31:0] a_word;
    logic [31:0] r0;
    logic [31:0] r1;
    int          waited;
    for (int i = 0; i < k; i++) begin
      a_word = next_random();
      r0 = next_random();
      r1 = next_random();
      model_a[i] = a_word[31:24];
      model_b[i] = {r0[31:16], r1[31:16]};
      // Upper bits of inputs_1 are noise, only the low byte counts
      run_cmd(WRITE_A, i, {a_word[23:0], a_word[31:24]}, 0, waited);
      run_cmd(WRITE_B, i, model_b[i], 0, waited);
    end
  endtask

  task automatic compute(input int k);
    int waited;
    run_cmd(COMPUTE, k, 32'h0, 0, waited);
    assert (waited >= k + 8) else begin
      proto_errors++;
      $display("COMPUTE with K=%0d answered after only %0d cycles", k, waited);
    end
    model_compute(k);
  endtask

  task automatic read_lane(input int j, input int hold);
    int waited;
    check_rsp = 1'b1;
    exp_rsp   = model_row[j];
    run_cmd(READ, 32'h0, j, hold, waited);
    check_rsp = 1'b0;
  endtask

  task automatic read_lanes();
    for (int j = 0; j < `CFU_LANES; j++) begin
      read_lane(j, 0);
    end
  endtask

  initial begin
    int waited;
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    rsp_ready    = 1'b1;
    seen_cmd     = 1'b0;
    short_cmd    = 1'b0;
    check_rsp    = 1'b0;
    exp_rsp      = '0;
    data_errors  = 0;
    proto_errors = 0;
    cmd_count    = 0;
    lcg_state    = 32'd42589;
    for (int j = 0; j < `CFU_LANES; j++) begin
      model_row[j] = '0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // Short and long dot products
    write_operands(K_SHORT);
    compute(K_SHORT);
    read_lanes();
    write_operands(K_LONG);
    compute(K_LONG);
    read_lanes();

    // Empty run, then a shorter run over the same buffers
    compute(0);
    read_lanes();
    compute(K_SMALL);
    read_lanes();

    // Unknown opcode leaves the result row alone
    run_cmd(7'h55, 32'h3, 32'h1234_5678, 0, waited);
    read_lanes();

    // Host stalls a read for six cycles
    read_lane(2, 6);
    read_lane(1, 0);

    repeat (2) @(negedge clk);
    $display("Done: %0d commands, %0d data errors, %0d protocol errors",
             cmd_count, data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the DUT did not finish the commands within %0d cycles",
             WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- cfu.f
+incdir+logic
logic/cfu_cmd_pkg.sv
logic/cfu_data_pkg.sv
logic/cmd_decode.sv
logic/operand_buffer.sv
logic/mac_pe.sv
logic/systolic_row.sv
logic/matmul_engine.sv
logic/result_store.sv
logic/cfu_top.sv
sim/cfu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cfu_tb -f cfu.f -Mdir obj_dir -o cfu_sim
./obj_dir/cfu_sim > sim.log
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log
